// ==== fractal_pixel_gen.f ====
+incdir+test
src/fractal_pkg.sv
src/fractal_if.sv
src/axi_lite_regs.sv
src/pixel_stepper.sv
src/escape_iterator.sv
src/stream_packer.sv
src/fractal_pixel_gen.sv
test/tb_fractal_pixel_gen.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert -Wno-fatal --top-module tb_fractal_pixel_gen \
        -f fractal_pixel_gen.f; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_fractal_pixel_gen 2>&1)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST PASSED$" <<< "$output"; then
    exit 0
fi
exit 1

// ==== test/fractal_model.svh ====
// Reference model for one pixel, signed 8.24 fixed point
// Products keep the full 64-bit result shifted down, sums wrap at 32 bits
`ifndef FRACTAL_MODEL_SVH
`define FRACTAL_MODEL_SVH

// Iterations of z = z*z + c from z = 0 until escape or the limit
function automatic int escape_count(input int c_re, input int c_im, input int limit);
    longint escape;
    longint mag;
    int     z_re;
    int     z_im;
    int     sq_re;
    int     sq_im;
    int     re_im;
    int     n;
    escape = longint'(4) <<< fractal_pkg::FRAC_BITS;  // 4.0
    z_re   = 0;
    z_im   = 0;
    n      = 0;
    while (n < limit) begin
        sq_re = int'((longint'(z_re) * longint'(z_re)) >>> fractal_pkg::FRAC_BITS);
        sq_im = int'((longint'(z_im) * longint'(z_im)) >>> fractal_pkg::FRAC_BITS);
        re_im = int'((longint'(z_re) * longint'(z_im)) >>> fractal_pkg::FRAC_BITS);
        mag   = longint'(sq_re) + longint'(sq_im);
        if (mag > escape) break;
        z_re = sq_re - sq_im + c_re;
        z_im = 2 * re_im + c_im;
        n++;
    end
    return n;
endfunction

// Zero top byte, red and green from the low byte, blue from the high byte
function automatic logic [31:0] pixel_colour(input int count);
    return {8'h00, count[7:0], count[7:0], count[15:8]};
endfunction

`endif

// ==== test/tb_fractal_pixel_gen.sv ====
// Testbench for the Mandelbrot pixel generator, first 1300 beats of one frame
// Expects limit 20 and a plane from (-2.0, 1.0) with step 1/160 rounded to 8.24
`timescale 1ns/1ps
`default_nettype none
`include "fractal_model.svh"

module tb_fractal_pixel_gen;
    import fractal_pkg::*;

    localparam int ONE            = 1 << FRAC_BITS;
    localparam int START_X        = -2 * ONE;
    localparam int START_Y        = ONE;
    localparam int STEP           = (ONE + 80) / 160;  // 1/160 rounded
    localparam int ITER_LIMIT     = 20;
    localparam int BEATS          = 1300;
    localparam int BUS_TIMEOUT    = 100;
    localparam int STREAM_TIMEOUT = 400000;
    localparam int ADDR_FIRST     = 0;
    localparam int DATA_FIRST     = 1;
    localparam int BOTH_AT_ONCE   = 2;

    logic                  out_stream_aclk;
    logic                  axi_resetn;
    logic [AXI_ADDR_W-1:0] s_axi_lite_awaddr_i;
    logic                  s_axi_lite_awvalid_i;
    logic                  s_axi_lite_awready_o;
    logic [31:0]           s_axi_lite_wdata_i;
    logic                  s_axi_lite_wvalid_i;
    logic                  s_axi_lite_wready_o;
    logic [1:0]            s_axi_lite_bresp_o;
    logic                  s_axi_lite_bvalid_o;
    logic                  s_axi_lite_bready_i;
    logic [AXI_ADDR_W-1:0] s_axi_lite_araddr_i;
    logic                  s_axi_lite_arvalid_i;
    logic                  s_axi_lite_arready_o;
    logic [31:0]           s_axi_lite_rdata_o;
    logic [1:0]            s_axi_lite_rresp_o;
    logic                  s_axi_lite_rvalid_o;
    logic                  s_axi_lite_rready_i;
    logic [31:0]           out_stream_tdata_o;
    logic [3:0]            out_stream_tkeep_o;
    logic                  out_stream_tlast_o;
    logic                  out_stream_tuser_o;
    logic                  out_stream_tvalid_o;
    logic                  out_stream_tready_i;
    int                    beat_count = 0;

    fractal_pixel_gen dut (.*);

    initial begin
        out_stream_aclk = 1'b0;
        forever #2 out_stream_aclk = ~out_stream_aclk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Failure reporting and timing helpers

    task automatic value_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] expected);
        $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, expected);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic wait_timeout(input string what);
        $display("Timeout: %s", what);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    // Inputs change 1 ns after the edge, outputs are settled by then
    task automatic tick();
        @(posedge out_stream_aclk);
        #1;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // AXI-Lite master

    task automatic offer_awaddr(input logic [AXI_ADDR_W-1:0] addr);
        int n;
        n = 0;
        s_axi_lite_awaddr_i  = addr;
        s_axi_lite_awvalid_i = 1'b1;
        while (!s_axi_lite_awready_o) begin
            tick();
            n++;
            if (n > BUS_TIMEOUT) wait_timeout("awready never rose");
        end
        tick();
        s_axi_lite_awvalid_i = 1'b0;
    endtask

    task automatic send_wdata(input logic [31:0] data);
        int n;
        n = 0;
        s_axi_lite_wdata_i  = data;
        s_axi_lite_wvalid_i = 1'b1;
        while (!s_axi_lite_wready_o) begin
            tick();
            n++;
            if (n > BUS_TIMEOUT) wait_timeout("wready never rose");
        end
        tick();
        s_axi_lite_wvalid_i = 1'b0;
    endtask

    task automatic write_reg(input logic [AXI_ADDR_W-1:0] addr, input logic [31:0] data,
                             input int order, output logic [1:0] resp);
        int n;
        n = 0;
        if (order == ADDR_FIRST) begin
            offer_awaddr(addr);
            send_wdata(data);
        end else if (order == DATA_FIRST) begin
            send_wdata(data);
            offer_awaddr(addr);
        end else begin
            s_axi_lite_awaddr_i  = addr;
            s_axi_lite_awvalid_i = 1'b1;
            s_axi_lite_wdata_i   = data;
            s_axi_lite_wvalid_i  = 1'b1;
            while (!(s_axi_lite_awready_o && s_axi_lite_wready_o)) begin
                tick();
                n++;
                if (n > BUS_TIMEOUT) wait_timeout("awready and wready never rose together");
            end
            tick();
            s_axi_lite_awvalid_i = 1'b0;
            s_axi_lite_wvalid_i  = 1'b0;
        end
        n = 0;
        s_axi_lite_bready_i = 1'b1;
        while (!s_axi_lite_bvalid_o) begin
            tick();
            n++;
            if (n > BUS_TIMEOUT) wait_timeout("no write response");
        end
        resp = s_axi_lite_bresp_o;
        tick();
        s_axi_lite_bready_i = 1'b0;
    endtask

    task automatic read_reg(input logic [AXI_ADDR_W-1:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        int n;
        n = 0;
        s_axi_lite_araddr_i  = addr;
        s_axi_lite_arvalid_i = 1'b1;
        while (!s_axi_lite_arready_o) begin
            tick();
            n++;
            if (n > BUS_TIMEOUT) wait_timeout("arready never rose");
        end
        tick();
        s_axi_lite_arvalid_i = 1'b0;
        s_axi_lite_rready_i  = 1'b1;
        n = 0;
        while (!s_axi_lite_rvalid_o) begin
            tick();
            n++;
            if (n > BUS_TIMEOUT) wait_timeout("no read data");
        end
        data = s_axi_lite_rdata_o;
        resp = s_axi_lite_rresp_o;
        tick();
        s_axi_lite_rready_i = 1'b0;
    endtask

    task automatic expect_write(input logic [AXI_ADDR_W-1:0] addr, input logic [31:0] data,
                                input int order, input logic [1:0] exp_resp);
        logic [1:0] resp;
        write_reg(addr, data, order, resp);
        assert (resp == exp_resp) else value_mismatch("s_axi_lite_bresp_o", resp, exp_resp);
    endtask

    task automatic expect_read(input logic [AXI_ADDR_W-1:0] addr, input logic [31:0] exp_data,
                               input logic [1:0] exp_resp);
        logic [31:0] data;
        logic [1:0]  resp;
        read_reg(addr, data, resp);
        assert (resp == exp_resp) else value_mismatch("s_axi_lite_rresp_o", resp, exp_resp);
        assert (data == exp_data) else value_mismatch("s_axi_lite_rdata_o", data, exp_data);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stream sink

    task automatic check_beat(input int n);
        int          x;
        int          y;
        logic [31:0] expected;
        x        = n % FRAME_W;
        y        = n / FRAME_W;
        expected = pixel_colour(escape_count(START_X + x * STEP, START_Y - y * STEP,
                                             ITER_LIMIT));
        assert (out_stream_tdata_o == expected)
            else value_mismatch("out_stream_tdata_o", out_stream_tdata_o, expected);
        assert (out_stream_tkeep_o == 4'hf)
            else value_mismatch("out_stream_tkeep_o", out_stream_tkeep_o, 4'hf);
        assert (out_stream_tuser_o == (n == 0))
            else value_mismatch("out_stream_tuser_o", out_stream_tuser_o, n == 0);
        assert (out_stream_tlast_o == (x == FRAME_W - 1))
            else value_mismatch("out_stream_tlast_o", out_stream_tlast_o, x == FRAME_W - 1);
    endtask

    initial begin : stream_sink
        logic        stall;
        logic [31:0] held_data;
        logic        held_last;
        logic        held_user;
        stall     = 1'b0;
        held_data = '0;
        held_last = 1'b0;
        held_user = 1'b0;
        void'($urandom(32'h40b55c2e));
        forever begin
            tick();
            if (stall) begin  // Beat was refused at the last edge
                assert (out_stream_tvalid_o)
                    else value_mismatch("out_stream_tvalid_o", out_stream_tvalid_o, 1'b1);
                assert (out_stream_tdata_o == held_data)
                    else value_mismatch("out_stream_tdata_o", out_stream_tdata_o, held_data);
                assert (out_stream_tlast_o == held_last)
                    else value_mismatch("out_stream_tlast_o", out_stream_tlast_o, held_last);
                assert (out_stream_tuser_o == held_user)
                    else value_mismatch("out_stream_tuser_o", out_stream_tuser_o, held_user);
            end
            out_stream_tready_i = ($urandom % 4) != 0;
            if (out_stream_tvalid_o && out_stream_tready_i) begin
                check_beat(beat_count);
                beat_count++;
            end
            stall     = out_stream_tvalid_o && !out_stream_tready_i;
            held_data = out_stream_tdata_o;
            held_last = out_stream_tlast_o;
            held_user = out_stream_tuser_o;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence

    initial begin : main_sequence
        int n;
        axi_resetn           = 1'b0;
        s_axi_lite_awaddr_i  = '0;
        s_axi_lite_awvalid_i = 1'b0;
        s_axi_lite_wdata_i   = '0;
        s_axi_lite_wvalid_i  = 1'b0;
        s_axi_lite_bready_i  = 1'b0;
        s_axi_lite_araddr_i  = '0;
        s_axi_lite_arvalid_i = 1'b0;
        s_axi_lite_rready_i  = 1'b0;
        out_stream_tready_i  = 1'b0;
        repeat (4) @(posedge out_stream_aclk);
        #1;
        axi_resetn = 1'b1;

        // Reset state
        assert (!s_axi_lite_bvalid_o) else value_mismatch("s_axi_lite_bvalid_o", 1'b1, 1'b0);
        assert (!s_axi_lite_rvalid_o) else value_mismatch("s_axi_lite_rvalid_o", 1'b1, 1'b0);
        assert (s_axi_lite_awready_o) else value_mismatch("s_axi_lite_awready_o", 1'b0, 1'b1);
        assert (s_axi_lite_wready_o) else value_mismatch("s_axi_lite_wready_o", 1'b0, 1'b1);
        assert (s_axi_lite_arready_o) else value_mismatch("s_axi_lite_arready_o", 1'b0, 1'b1);
        assert (!out_stream_tvalid_o) else value_mismatch("out_stream_tvalid_o", 1'b1, 1'b0);
        for (int i = 0; i < REG_COUNT; i++) begin
            expect_read(AXI_ADDR_W'(i * 4), 32'h0, RESP_OKAY);
        end

        // Every write ordering, then read back
        expect_write(8'h04, START_X, ADDR_FIRST, RESP_OKAY);
        expect_write(8'h08, START_Y, DATA_FIRST, RESP_OKAY);
        expect_write(8'h0c, STEP, BOTH_AT_ONCE, RESP_OKAY);
        expect_write(8'h10, ITER_LIMIT, ADDR_FIRST, RESP_OKAY);
        expect_write(8'h14, 32'h5a5a_c3c3, DATA_FIRST, RESP_OKAY);
        expect_write(8'h18, 32'h0123_4567, BOTH_AT_ONCE, RESP_OKAY);
        expect_read(8'h04, START_X, RESP_OKAY);
        expect_read(8'h08, START_Y, RESP_OKAY);
        expect_read(8'h0c, STEP, RESP_OKAY);
        expect_read(8'h10, ITER_LIMIT, RESP_OKAY);
        expect_read(8'h14, 32'h5a5a_c3c3, RESP_OKAY);
        expect_read(8'h18, 32'h0123_4567, RESP_OKAY);

        // Out of range address, writes must be dropped
        for (int order = ADDR_FIRST; order <= BOTH_AT_ONCE; order++) begin
            expect_write(8'h40, 32'hffff_ffff, order, RESP_SLVERR);
        end
        expect_read(8'h40, 32'h0, RESP_SLVERR);
        expect_read(8'h14, 32'h5a5a_c3c3, RESP_OKAY);
        expect_read(8'h00, 32'h0, RESP_OKAY);

        // No output while run is clear
        for (int i = 0; i < 50; i++) begin
            tick();
            assert (!out_stream_tvalid_o)
                else value_mismatch("out_stream_tvalid_o", out_stream_tvalid_o, 1'b0);
        end

        expect_write(8'h00, 32'h1, ADDR_FIRST, RESP_OKAY);
        n = 0;
        while (beat_count < BEATS) begin
            tick();
            n++;
            if (n > STREAM_TIMEOUT) wait_timeout("fewer than 1300 stream beats arrived");
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/fractal_pixel_gen.sv ====
// Mandelbrot generator top with one clock and one active-low synchronous reset
// Nothing is streamed until software sets the run bit in register 0
`timescale 1ns/1ps
`default_nettype none

module fractal_pixel_gen (
    input  wire                               out_stream_aclk,
    input  wire                               axi_resetn,
    input  wire [fractal_pkg::AXI_ADDR_W-1:0] s_axi_lite_awaddr_i,
    input  wire                               s_axi_lite_awvalid_i,
    output logic                              s_axi_lite_awready_o,
    input  wire [31:0]                        s_axi_lite_wdata_i,
    input  wire                               s_axi_lite_wvalid_i,
    output logic                              s_axi_lite_wready_o,
    output logic [1:0]                        s_axi_lite_bresp_o,
    output logic                              s_axi_lite_bvalid_o,
    input  wire                               s_axi_lite_bready_i,
    input  wire [fractal_pkg::AXI_ADDR_W-1:0] s_axi_lite_araddr_i,
    input  wire                               s_axi_lite_arvalid_i,
    output logic                              s_axi_lite_arready_o,
    output logic [31:0]                       s_axi_lite_rdata_o,
    output logic [1:0]                        s_axi_lite_rresp_o,
    output logic                              s_axi_lite_rvalid_o,
    input  wire                               s_axi_lite_rready_i,
    output logic [31:0]                       out_stream_tdata_o,
    output logic [3:0]                        out_stream_tkeep_o,
    output logic                              out_stream_tlast_o,
    output logic                              out_stream_tuser_o,
    output logic                              out_stream_tvalid_o,
    input  wire                               out_stream_tready_i
);
    import fractal_pkg::*;

    logic  run;
    fix_t  start_x;
    fix_t  start_y;
    fix_t  step;
    iter_t max_iter;

    pixel_job_if    job_if ();
    pixel_result_if res_if ();

    axi_lite_regs u_regs (
        .out_stream_aclk      (out_stream_aclk),
        .axi_resetn           (axi_resetn),
        .s_axi_lite_awaddr_i  (s_axi_lite_awaddr_i),
        .s_axi_lite_awvalid_i (s_axi_lite_awvalid_i),
        .s_axi_lite_awready_o (s_axi_lite_awready_o),
        .s_axi_lite_wdata_i   (s_axi_lite_wdata_i),
        .s_axi_lite_wvalid_i  (s_axi_lite_wvalid_i),
        .s_axi_lite_wready_o  (s_axi_lite_wready_o),
        .s_axi_lite_bresp_o   (s_axi_lite_bresp_o),
        .s_axi_lite_bvalid_o  (s_axi_lite_bvalid_o),
        .s_axi_lite_bready_i  (s_axi_lite_bready_i),
        .s_axi_lite_araddr_i  (s_axi_lite_araddr_i),
        .s_axi_lite_arvalid_i (s_axi_lite_arvalid_i),
        .s_axi_lite_arready_o (s_axi_lite_arready_o),
        .s_axi_lite_rdata_o   (s_axi_lite_rdata_o),
        .s_axi_lite_rresp_o   (s_axi_lite_rresp_o),
        .s_axi_lite_rvalid_o  (s_axi_lite_rvalid_o),
        .s_axi_lite_rready_i  (s_axi_lite_rready_i),
        .run_o                (run),
        .start_x_o            (start_x),
        .start_y_o            (start_y),
        .step_o               (step),
        .max_iter_o           (max_iter)
    );

    pixel_stepper u_stepper (
        .out_stream_aclk (out_stream_aclk),
        .axi_resetn      (axi_resetn),
        .run_i           (run),
        .start_x_i       (start_x),
        .start_y_i       (start_y),
        .step_i          (step),
        .job             (job_if.source)
    );

    escape_iterator u_iter (
        .out_stream_aclk (out_stream_aclk),
        .axi_resetn      (axi_resetn),
        .max_iter_i      (max_iter),
        .job             (job_if.sink),
        .result          (res_if.source)
    );

    stream_packer u_packer (
        .out_stream_aclk     (out_stream_aclk),
        .axi_resetn          (axi_resetn),
        .result              (res_if.sink),
        .out_stream_tdata_o  (out_stream_tdata_o),
        .out_stream_tkeep_o  (out_stream_tkeep_o),
        .out_stream_tlast_o  (out_stream_tlast_o),
        .out_stream_tuser_o  (out_stream_tuser_o),
        .out_stream_tvalid_o (out_stream_tvalid_o),
        .out_stream_tready_i (out_stream_tready_i)
    );

endmodule

`default_nettype wire

// ==== src/stream_packer.sv ====
// Colour mapping and the single AXI-Stream output register
// tdata is {0, red, green, blue}; red and green are count[7:0], blue is count[15:8]
`timescale 1ns/1ps
`default_nettype none

module stream_packer (
    input  wire          out_stream_aclk,
    input  wire          axi_resetn,
    pixel_result_if.sink result,
    output logic [31:0]  out_stream_tdata_o,
    output logic [3:0]   out_stream_tkeep_o,
    output logic         out_stream_tlast_o,
    output logic         out_stream_tuser_o,
    output logic         out_stream_tvalid_o,
    input  wire          out_stream_tready_i
);

    // Take a new result when empty or when the held beat leaves this cycle
    assign result.ready = !out_stream_tvalid_o || out_stream_tready_i;

    always_ff @(posedge out_stream_aclk) begin
        if (!axi_resetn) begin
            out_stream_tvalid_o <= 1'b0;
        end else if (result.valid && result.ready) begin
            out_stream_tvalid_o <= 1'b1;
        end else if (out_stream_tready_i) begin
            out_stream_tvalid_o <= 1'b0;
        end
    end

    always_ff @(posedge out_stream_aclk) begin
        if (result.valid && result.ready) begin
            out_stream_tdata_o <= {8'h00, result.count[7:0], result.count[7:0],
                                   result.count[15:8]};
            out_stream_tuser_o <= result.first;
            out_stream_tlast_o <= result.eol;
        end
    end

    assign out_stream_tkeep_o = 4'hf;

    a_beat_hold: assert property (@(posedge out_stream_aclk) disable iff (!axi_resetn)
        out_stream_tvalid_o && !out_stream_tready_i |=> out_stream_tvalid_o
            && $stable(out_stream_tdata_o));

endmodule

`default_nettype wire

// ==== src/escape_iterator.sv ====
// One Mandelbrot iteration per cycle in signed 8.24, products truncated, sums wrap
// Takes a new job only when idle and no result is waiting
`timescale 1ns/1ps
`default_nettype none

module escape_iterator (
    input  wire                 out_stream_aclk,
    input  wire                 axi_resetn,
    input  fractal_pkg::iter_t  max_iter_i,
    pixel_job_if.sink           job,
    pixel_result_if.source      result
);
    import fractal_pkg::*;

    logic              busy;
    logic              done;
    fix_t              c_re;
    fix_t              c_im;
    fix_t              z_re;
    fix_t              z_im;
    iter_t             count;
    logic              first_q;
    logic              eol_q;
    logic signed [63:0] p_rr;
    logic signed [63:0] p_ii;
    logic signed [63:0] p_ri;
    fix_t              sq_re;
    fix_t              sq_im;
    fix_t              re_im;
    logic signed [FIX_W:0] mag;
    logic              stop;

    // Full products, then drop the extra fraction bits
    assign p_rr  = z_re * z_re;
    assign p_ii  = z_im * z_im;
    assign p_ri  = z_re * z_im;
    assign sq_re = p_rr[FRAC_BITS +: FIX_W];
    assign sq_im = p_ii[FRAC_BITS +: FIX_W];
    assign re_im = p_ri[FRAC_BITS +: FIX_W];

    assign mag  = {sq_re[FIX_W-1], sq_re} + {sq_im[FIX_W-1], sq_im};  // One bit wider
    assign stop = (mag > ESCAPE_LIMIT) || (count >= max_iter_i);

    always_ff @(posedge out_stream_aclk) begin
        if (!axi_resetn) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else if (job.valid && job.ready) begin
            busy <= 1'b1;
        end else if (busy && stop) begin
            busy <= 1'b0;
            done <= 1'b1;
        end else if (result.valid && result.ready) begin
            done <= 1'b0;
        end
    end

    always_ff @(posedge out_stream_aclk) begin
        if (job.valid && job.ready) begin
            c_re    <= job.c_re;
            c_im    <= job.c_im;
            z_re    <= '0;
            z_im    <= '0;
            count   <= '0;
            first_q <= job.first;
            eol_q   <= job.eol;
        end else if (busy && !stop) begin
            z_re  <= sq_re - sq_im + c_re;
            z_im  <= (re_im <<< 1) + c_im;  // 2*re*im
            count <= count + 1'b1;
        end
    end

    assign job.ready    = !busy && !done;
    assign result.valid = done;
    assign result.count = count;
    assign result.first = first_q;
    assign result.eol   = eol_q;

    a_count_limit: assert property (@(posedge out_stream_aclk) disable iff (!axi_resetn)
        result.valid |-> result.count <= max_iter_i);

endmodule

`default_nettype wire

// ==== src/pixel_stepper.sv ====
// Walks the plane in raster order, one job per pixel while run is set
// Start values are taken only at line and frame reloads; step is used live
`timescale 1ns/1ps
`default_nettype none

module pixel_stepper (
    input  wire                out_stream_aclk,
    input  wire                axi_resetn,
    input  wire                run_i,
    input  fractal_pkg::fix_t  start_x_i,
    input  fractal_pkg::fix_t  start_y_i,
    input  fractal_pkg::fix_t  step_i,
    pixel_job_if.source        job
);
    import fractal_pkg::*;

    logic [X_W-1:0] x;
    logic [Y_W-1:0] y;
    fix_t           c_re;
    fix_t           c_im;
    logic           last_x;
    logic           last_y;

    assign last_x = (x == X_W'(FRAME_W - 1));
    assign last_y = (y == Y_W'(FRAME_H - 1));

    always_ff @(posedge out_stream_aclk) begin
        if (!axi_resetn || !run_i) begin  // Parked at (0,0)
            x    <= '0;
            y    <= '0;
            c_re <= start_x_i;
            c_im <= start_y_i;
        end else if (job.valid && job.ready) begin
            if (last_x) begin
                x    <= '0;
                c_re <= start_x_i;
                if (last_y) begin
                    y    <= '0;
                    c_im <= start_y_i;
                end else begin
                    y    <= y + 1'b1;
                    c_im <= c_im - step_i;  // Imaginary axis runs downward
                end
            end else begin
                x    <= x + 1'b1;
                c_re <= c_re + step_i;
            end
        end
    end

    assign job.valid = run_i;
    assign job.c_re  = c_re;
    assign job.c_im  = c_im;
    assign job.first = (x == '0) && (y == '0);
    assign job.eol   = last_x;

    a_job_stable: assert property (@(posedge out_stream_aclk) disable iff (!axi_resetn)
        job.valid && !job.ready |=> !run_i
            || ($stable(job.c_re) && $stable(job.c_im) && $stable(job.first) && $stable(job.eol)));

endmodule

`default_nettype wire

// ==== src/axi_lite_regs.sv ====
// AXI-Lite slave with eight 32-bit registers, no wstrb, no burst
// Any address bit above bit 4 set gives SLVERR; such writes are dropped, reads give zero
`timescale 1ns/1ps
`default_nettype none

module axi_lite_regs (
    input  wire                                   out_stream_aclk,
    input  wire                                   axi_resetn,
    input  wire [fractal_pkg::AXI_ADDR_W-1:0]     s_axi_lite_awaddr_i,
    input  wire                                   s_axi_lite_awvalid_i,
    output logic                                  s_axi_lite_awready_o,
    input  wire [31:0]                            s_axi_lite_wdata_i,
    input  wire                                   s_axi_lite_wvalid_i,
    output logic                                  s_axi_lite_wready_o,
    output logic [1:0]                            s_axi_lite_bresp_o,
    output logic                                  s_axi_lite_bvalid_o,
    input  wire                                   s_axi_lite_bready_i,
    input  wire [fractal_pkg::AXI_ADDR_W-1:0]     s_axi_lite_araddr_i,
    input  wire                                   s_axi_lite_arvalid_i,
    output logic                                  s_axi_lite_arready_o,
    output logic [31:0]                           s_axi_lite_rdata_o,
    output logic [1:0]                            s_axi_lite_rresp_o,
    output logic                                  s_axi_lite_rvalid_o,
    input  wire                                   s_axi_lite_rready_i,
    output logic                                  run_o,
    output fractal_pkg::fix_t                     start_x_o,
    output fractal_pkg::fix_t                     start_y_o,
    output fractal_pkg::fix_t                     step_o,
    output fractal_pkg::iter_t                    max_iter_o
);
    import fractal_pkg::*;

    logic [31:0]          regs [REG_COUNT];
    wr_state_e            wr_state;
    rd_state_e            rd_state;
    logic [REG_IDX_W-1:0] wr_idx;
    logic [REG_IDX_W-1:0] rd_idx;
    logic [31:0]          wr_data;
    logic                 wr_err;
    logic                 rd_err;
    logic [31:0]          rd_data;

    ////////////////////////////////////////////////////////////////////////////
    // Write side

    always_ff @(posedge out_stream_aclk) begin
        if (!axi_resetn) begin
            wr_state <= wr_idle;
            wr_err   <= 1'b0;
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (s_axi_lite_awvalid_i && s_axi_lite_awready_o) begin
                wr_idx <= s_axi_lite_awaddr_i[2 +: REG_IDX_W];
                wr_err <= |s_axi_lite_awaddr_i[AXI_ADDR_W-1:5];
            end
            if (s_axi_lite_wvalid_i && s_axi_lite_wready_o) begin
                wr_data <= s_axi_lite_wdata_i;
            end
            case (wr_state)
                wr_idle: begin
                    case ({s_axi_lite_awvalid_i, s_axi_lite_wvalid_i})
                        2'b11:   wr_state <= wr_commit;
                        2'b10:   wr_state <= wr_need_data;
                        2'b01:   wr_state <= wr_need_addr;
                        default: wr_state <= wr_idle;
                    endcase
                end
                wr_need_data: if (s_axi_lite_wvalid_i) wr_state <= wr_commit;
                wr_need_addr: if (s_axi_lite_awvalid_i) wr_state <= wr_commit;
                wr_commit: begin
                    if (!wr_err) begin
                        regs[wr_idx] <= wr_data;
                    end
                    wr_state <= wr_resp;
                end
                wr_resp: if (s_axi_lite_bready_i) wr_state <= wr_idle;
                default: wr_state <= wr_idle;
            endcase
        end
    end

    assign s_axi_lite_awready_o = (wr_state == wr_idle) || (wr_state == wr_need_addr);
    assign s_axi_lite_wready_o  = (wr_state == wr_idle) || (wr_state == wr_need_data);
    assign s_axi_lite_bvalid_o  = (wr_state == wr_resp);
    assign s_axi_lite_bresp_o   = wr_err ? RESP_SLVERR : RESP_OKAY;

    ////////////////////////////////////////////////////////////////////////////
    // Read side, one fetch cycle before rvalid

    always_ff @(posedge out_stream_aclk) begin
        if (!axi_resetn) begin
            rd_state <= rd_idle;
            rd_err   <= 1'b0;
        end else begin
            case (rd_state)
                rd_idle: begin
                    if (s_axi_lite_arvalid_i) begin
                        rd_idx   <= s_axi_lite_araddr_i[2 +: REG_IDX_W];
                        rd_err   <= |s_axi_lite_araddr_i[AXI_ADDR_W-1:5];
                        rd_state <= rd_fetch;
                    end
                end
                rd_fetch: begin
                    rd_data  <= rd_err ? '0 : regs[rd_idx];
                    rd_state <= rd_resp;
                end
                rd_resp: if (s_axi_lite_rready_i) rd_state <= rd_idle;
                default: rd_state <= rd_idle;
            endcase
        end
    end

    assign s_axi_lite_arready_o = (rd_state == rd_idle);
    assign s_axi_lite_rvalid_o  = (rd_state == rd_resp);
    assign s_axi_lite_rdata_o   = rd_data;
    assign s_axi_lite_rresp_o   = rd_err ? RESP_SLVERR : RESP_OKAY;

    // Register map to the pipeline
    assign run_o      = regs[REG_CTRL][0];
    assign start_x_o  = fix_t'(regs[REG_START_X]);
    assign start_y_o  = fix_t'(regs[REG_START_Y]);
    assign step_o     = fix_t'(regs[REG_STEP]);
    assign max_iter_o = regs[REG_MAX_ITER][ITER_W-1:0];

    // A response stays up and unchanged until the master takes it
    a_b_hold: assert property (@(posedge out_stream_aclk) disable iff (!axi_resetn)
        s_axi_lite_bvalid_o && !s_axi_lite_bready_i |=> s_axi_lite_bvalid_o
            && $stable(s_axi_lite_bresp_o));
    a_r_hold: assert property (@(posedge out_stream_aclk) disable iff (!axi_resetn)
        s_axi_lite_rvalid_o && !s_axi_lite_rready_i |=> s_axi_lite_rvalid_o
            && $stable(s_axi_lite_rdata_o) && $stable(s_axi_lite_rresp_o));
    a_legal_state: assert property (@(posedge out_stream_aclk) disable iff (!axi_resetn)
        wr_state inside {wr_idle, wr_need_data, wr_need_addr, wr_commit, wr_resp}
            && rd_state inside {rd_idle, rd_fetch, rd_resp});

endmodule

`default_nettype wire

// ==== src/fractal_if.sv ====
// Valid/ready links between the pipeline stages
// Payload and markers must hold while valid is high and ready is low
`timescale 1ns/1ps
`default_nettype none

// Stepper to iterator
interface pixel_job_if;
    import fractal_pkg::*;

    logic valid;
    logic ready;
    fix_t c_re;
    fix_t c_im;
    logic first;  // Raster pixel (0,0)
    logic eol;

    modport source (output valid, c_re, c_im, first, eol, input ready);
    modport sink   (input valid, c_re, c_im, first, eol, output ready);
endinterface

// Iterator to packer
interface pixel_result_if;
    import fractal_pkg::*;

    logic  valid;
    logic  ready;
    iter_t count;
    logic  first;
    logic  eol;

    modport source (output valid, count, first, eol, input ready);
    modport sink   (input valid, count, first, eol, output ready);
endinterface

`default_nettype wire

// ==== src/fractal_pkg.sv ====
// Shared widths, register map and fixed-point constants for the pixel generator
// Coordinates are signed 8.24, so the visible plane is limited to about +/-128
`default_nettype none

package fractal_pkg;

    // Fixed point and counts
    localparam int FIX_W     = 32;
    localparam int FRAC_BITS = 24;
    localparam int ITER_W    = 16;

    // Raster
    localparam int FRAME_W = 640;
    localparam int FRAME_H = 480;
    localparam int X_W     = 10;
    localparam int Y_W     = 9;

    // Register file, index from address bits 4:2
    localparam int AXI_ADDR_W = 8;
    localparam int REG_COUNT  = 8;
    localparam int REG_IDX_W  = 3;

    localparam logic [REG_IDX_W-1:0] REG_CTRL     = 3'd0;  // Bit 0 is run
    localparam logic [REG_IDX_W-1:0] REG_START_X  = 3'd1;
    localparam logic [REG_IDX_W-1:0] REG_START_Y  = 3'd2;
    localparam logic [REG_IDX_W-1:0] REG_STEP     = 3'd3;
    localparam logic [REG_IDX_W-1:0] REG_MAX_ITER = 3'd4;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    typedef logic signed [FIX_W-1:0] fix_t;
    typedef logic [ITER_W-1:0]       iter_t;

    localparam fix_t ESCAPE_LIMIT = 32'h0400_0000;  // 4.0

    typedef enum logic [2:0] {wr_idle, wr_need_data, wr_need_addr, wr_commit, wr_resp} wr_state_e;
    typedef enum logic [1:0] {rd_idle, rd_fetch, rd_resp} rd_state_e;

endpackage

`default_nettype wire
